// ==== mem_stage_pkg.sv ====
package mem_stage_pkg;

    localparam int DATA_W = 32;          // Four byte lanes assumed throughout
    localparam int LANES  = DATA_W / 8;
    localparam int OP_W   = 2;
    localparam int SIZE_W = 2;
    localparam int FLAG_W = 2;           // Zero flag and branch flag

    typedef enum logic [OP_W-1:0] {
        MEM_NOP   = 2'b00,               // Pass ALU result through
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10                // Write memory, pass address through
    } mem_op_t;

    // Two-bit access size code that also selects the byte mask
    typedef enum logic [SIZE_W-1:0] {
        SZ_WORD = 2'b00,
        SZ_TRI  = 2'b01,
        SZ_HALF = 2'b10,
        SZ_BYTE = 2'b11
    } mem_size_t;

    // Queue entry, msb first: op, size, zero, branch, addr, wdata
    function automatic int req_w_of(input int addr_w);
        return OP_W + SIZE_W + FLAG_W + addr_w + DATA_W;
    endfunction

endpackage

// ==== mem_req_queue.sv ====
`timescale 1ns/1ps

module mem_req_queue
    import mem_stage_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_W      = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_push,
    input  logic [req_w_of(ADDR_W)-1:0]   i_push_data,
    input  logic                          i_pop,
    output logic [req_w_of(ADDR_W)-1:0]   o_head_data,
    output logic                          o_empty,
    output logic                          o_credit
);

    localparam int REQ_W = req_w_of(ADDR_W);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [REQ_W-1:0] slots [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;           // One extra bit to hold a full count

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;                 // Wrap for non power of two depths too
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (i_push) begin
            slots[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push and pop together
            endcase
        end
    end

    // One credit back to execute for every entry that leaves
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_credit <= 1'b0;
        end else begin
            o_credit <= i_pop;
        end
    end

    assign o_head_data = slots[rd_ptr];
    assign o_empty     = (count == '0);

endmodule

// ==== data_memory.sv ====
`timescale 1ns/1ps

module data_memory
    import mem_stage_pkg::*;
#(
    parameter int MEM_BYTES = 64,
    parameter int ADDR_W    = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_wr_en,
    input  logic              i_rd_en,
    input  mem_size_t         i_size,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [ADDR_W-1:0] i_dbg_addr,
    output logic [DATA_W-1:0] o_rdata,
    output logic [DATA_W-1:0] o_dbg_data
);

    // Little endian: lowest address lands in the least significant byte
    logic [7:0]        mem [MEM_BYTES];
    logic [LANES-1:0]  lane_en;
    logic [DATA_W-1:0] lane_mask;
    logic [DATA_W-1:0] acc_word;
    logic [DATA_W-1:0] dbg_word;

    // Gathers four consecutive bytes with the address wrapping at the top
    function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] base);
        logic [DATA_W-1:0] word;
        logic [ADDR_W-1:0] a;
        word = '0;
        for (int k = 0; k < LANES; k++) begin
            a = base + ADDR_W'(k);
            word[8*k +: 8] = mem[a];
        end
        return word;
    endfunction

    always_comb begin
        case (i_size)
            SZ_WORD: lane_en = 4'b1111;
            SZ_TRI:  lane_en = 4'b0111;
            SZ_HALF: lane_en = 4'b0011;
            SZ_BYTE: lane_en = 4'b0001;
            default: lane_en = 4'b1111;
        endcase
    end

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_mask[8*k +: 8] = {8{lane_en[k]}};
        end
    end

    assign acc_word = word_at(i_addr);
    assign dbg_word = word_at(i_dbg_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= '0;              // Whole array reads zero after reset
            end
        end else if (i_wr_en) begin
            for (int k = 0; k < LANES; k++) begin
                if (lane_en[k]) begin
                    mem[i_addr + ADDR_W'(k)] <= i_wdata[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rdata <= acc_word & lane_mask;  // Zero-extend unused upper lanes
        end
    end

    always_ff @(posedge clk) begin
        o_dbg_data <= dbg_word;           // Debug port sampled every edge
    end

endmodule

// ==== mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl
    import mem_stage_pkg::*;
#(
    parameter int RES_CREDITS = 2,
    parameter int ADDR_W      = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_empty,
    input  logic [req_w_of(ADDR_W)-1:0]   i_head_data,
    input  logic                          i_res_credit,
    input  logic [DATA_W-1:0]             i_rdata,
    output logic                          o_pop,
    output logic                          o_mem_wr,
    output logic                          o_mem_rd,
    output mem_size_t                     o_mem_size,
    output logic [ADDR_W-1:0]             o_mem_addr,
    output logic [DATA_W-1:0]             o_mem_wdata,
    output logic                          o_res_valid,
    output logic [DATA_W-1:0]             o_res_data,
    output logic                          o_res_pc_src,
    output logic                          o_res_is_load
);

    localparam int BR_BIT   = DATA_W + ADDR_W;
    localparam int ZERO_BIT = BR_BIT + 1;
    localparam int SIZE_LSB = ZERO_BIT + 1;
    localparam int OP_LSB   = SIZE_LSB + SIZE_W;
    localparam int CNT_W    = $clog2(RES_CREDITS + 1);

    mem_op_t           head_op;
    logic              head_zero;
    logic              head_branch;
    logic [CNT_W-1:0]  credits;
    mem_op_t           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic              pc_src_q;

    // Unpack the head entry
    assign head_op     = mem_op_t'(i_head_data[OP_LSB +: OP_W]);
    assign o_mem_size  = mem_size_t'(i_head_data[SIZE_LSB +: SIZE_W]);
    assign head_zero   = i_head_data[ZERO_BIT];
    assign head_branch = i_head_data[BR_BIT];
    assign o_mem_addr  = i_head_data[DATA_W +: ADDR_W];
    assign o_mem_wdata = i_head_data[DATA_W-1:0];

    // Issue only with a writeback credit in hand
    assign o_pop    = !i_empty && (credits != '0);
    assign o_mem_wr = o_pop && (head_op == MEM_STORE);
    assign o_mem_rd = o_pop && (head_op == MEM_LOAD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CNT_W'(RES_CREDITS);
        end else if (i_res_credit && !o_pop) begin
            credits <= credits + CNT_W'(1);
        end else if (!i_res_credit && o_pop) begin
            credits <= credits - CNT_W'(1);  // Return and spend together cancel
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_res_valid <= 1'b0;
            op_q        <= MEM_NOP;
        end else begin
            o_res_valid <= o_pop;
            if (o_pop) begin
                op_q <= head_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            addr_q   <= o_mem_addr;
            pc_src_q <= head_zero & head_branch;  // Branch taken decision
        end
    end

    // Memory read data arrives in the same cycle as the registered op
    assign o_res_data    = (op_q == MEM_LOAD) ? i_rdata : DATA_W'(addr_q);
    assign o_res_pc_src  = pc_src_q;
    assign o_res_is_load = (op_q == MEM_LOAD);

endmodule

// ==== mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int MEM_BYTES   = 64,
    parameter int QUEUE_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_req_valid,
    input  mem_op_t                      i_req_op,
    input  mem_size_t                    i_req_size,
    input  logic [$clog2(MEM_BYTES)-1:0] i_req_addr,
    input  logic [DATA_W-1:0]            i_req_wdata,
    input  logic                         i_req_zero,
    input  logic                         i_req_branch,
    input  logic                         i_res_credit,
    input  logic [$clog2(MEM_BYTES)-1:0] i_dbg_addr,
    output logic                         o_req_credit,
    output logic                         o_res_valid,
    output logic [DATA_W-1:0]            o_res_data,
    output logic                         o_res_pc_src,
    output logic                         o_res_is_load,
    output logic [DATA_W-1:0]            o_dbg_data
);

    localparam int ADDR_W = $clog2(MEM_BYTES);
    localparam int REQ_W  = req_w_of(ADDR_W);

    logic [REQ_W-1:0]  req_entry;
    logic [REQ_W-1:0]  head_data;
    logic              q_empty;
    logic              pop;
    logic              mem_wr;
    logic              mem_rd;
    mem_size_t         mem_size;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;

    assign req_entry = {i_req_op, i_req_size, i_req_zero, i_req_branch,
                        i_req_addr, i_req_wdata};  // Layout matches the package

    mem_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .ADDR_W(ADDR_W)) mem_req_queue_inst (
        .clk(clk), .rst(rst),
        .i_push(i_req_valid), .i_push_data(req_entry), .i_pop(pop),
        .o_head_data(head_data), .o_empty(q_empty), .o_credit(o_req_credit)
    );

    mem_access_ctrl #(.RES_CREDITS(RES_CREDITS), .ADDR_W(ADDR_W)) mem_access_ctrl_inst (
        .clk(clk), .rst(rst),
        .i_empty(q_empty), .i_head_data(head_data),
        .i_res_credit(i_res_credit), .i_rdata(mem_rdata),
        .o_pop(pop), .o_mem_wr(mem_wr), .o_mem_rd(mem_rd),
        .o_mem_size(mem_size), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
        .o_res_valid(o_res_valid), .o_res_data(o_res_data),
        .o_res_pc_src(o_res_pc_src), .o_res_is_load(o_res_is_load)
    );

    data_memory #(.MEM_BYTES(MEM_BYTES), .ADDR_W(ADDR_W)) data_memory_inst (
        .clk(clk), .rst(rst),
        .i_wr_en(mem_wr), .i_rd_en(mem_rd), .i_size(mem_size),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .i_dbg_addr(i_dbg_addr),
        .o_rdata(mem_rdata), .o_dbg_data(o_dbg_data)
    );

endmodule

// ==== mem_stage_assert.sv ====
`timescale 1ns/1ps

module mem_stage_assert #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic i_req_valid,
    input logic i_res_credit,
    input logic i_pop,
    input logic i_res_valid,
    input logic i_req_credit
);

    int held;                              // Writeback credits the stage holds
    int occ;                               // Queue occupancy

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held <= RES_CREDITS;
            occ  <= 0;
        end else begin
            held <= held + int'(i_res_credit) - int'(i_pop);
            occ  <= occ + int'(i_req_valid) - int'(i_pop);
        end
    end

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        i_res_valid |-> $past(i_pop) && ($past(held) > 0))
        else $error("Result sent without a writeback credit");

    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        i_req_valid |-> occ < QUEUE_DEPTH)
        else $error("Request pushed into a full queue");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !i_res_valid && !i_req_credit)
        else $error("Handshake outputs active during reset");

endmodule

bind mem_stage_top mem_stage_assert #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RES_CREDITS(RES_CREDITS)
) mem_stage_assert_inst (
    .clk(clk),
    .rst(rst),
    .i_req_valid(i_req_valid),
    .i_res_credit(i_res_credit),
    .i_pop(pop),
    .i_res_valid(o_res_valid),
    .i_req_credit(o_req_credit)
);

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage
    import mem_stage_pkg::*;
();

    localparam int MEM_BYTES   = 64;
    localparam int QUEUE_DEPTH = 4;
    localparam int RES_CREDITS = 2;
    localparam int ADDR_W      = $clog2(MEM_BYTES);
    localparam int NUM_REQ     = 16;
    localparam int IDX_W       = $clog2(NUM_REQ);
    localparam int HOLD_FIRST  = 10;      // Entries from here on run with credits withheld
    localparam int TIMEOUT     = 200;     // Cycles allowed for any single wait

    typedef struct packed {
        mem_op_t           op;
        mem_size_t         size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              zero;
        logic              branch;
        logic [DATA_W-1:0] exp_data;
    } stim_t;

    logic              clk;
    logic              rst;
    logic              i_req_valid;
    mem_op_t           i_req_op;
    mem_size_t         i_req_size;
    logic [ADDR_W-1:0] i_req_addr;
    logic [DATA_W-1:0] i_req_wdata;
    logic              i_req_zero;
    logic              i_req_branch;
    logic              i_res_credit = 1'b0;
    logic [ADDR_W-1:0] i_dbg_addr;
    logic              o_req_credit;
    logic              o_res_valid;
    logic [DATA_W-1:0] o_res_data;
    logic              o_res_pc_src;
    logic              o_res_is_load;
    logic [DATA_W-1:0] o_dbg_data;

    logic [7:0]        ref_mem [MEM_BYTES];   // Reference byte array
    logic [DATA_W-1:0] exp_data [NUM_REQ];    // Expected results in request order
    logic              exp_pc [NUM_REQ];
    logic              exp_load [NUM_REQ];
    logic              hold_credits = 1'b0;
    int                sent = 0;
    int                results_seen = 0;
    int                credits_back = 0;
    int                owed = 0;              // Credits writeback still has to return
    int                gap = 0;
    int                seed = 6394;

    // Opcode, size, address, store data, zero, branch, expected result
    stim_t stim [NUM_REQ] = '{
        '{MEM_STORE, SZ_WORD, 6'h10, 32'hA1B2C3D4, 1'b0, 1'b0, 32'h0000_0010},
        '{MEM_LOAD,  SZ_WORD, 6'h10, 32'h0000_0000, 1'b0, 1'b0, 32'hA1B2_C3D4},
        '{MEM_STORE, SZ_WORD, 6'h20, 32'hFFFF_FFFF, 1'b0, 1'b0, 32'h0000_0020},
        '{MEM_STORE, SZ_BYTE, 6'h21, 32'h1234_5655, 1'b0, 1'b0, 32'h0000_0021},
        '{MEM_STORE, SZ_HALF, 6'h22, 32'hCAFE_1357, 1'b0, 1'b0, 32'h0000_0022},
        '{MEM_LOAD,  SZ_WORD, 6'h20, 32'h0000_0000, 1'b0, 1'b0, 32'h1357_55FF},
        '{MEM_STORE, SZ_TRI,  6'h0D, 32'h9988_7766, 1'b0, 1'b0, 32'h0000_000D},
        '{MEM_LOAD,  SZ_TRI,  6'h0D, 32'h0000_0000, 1'b0, 1'b0, 32'h0088_7766},
        '{MEM_LOAD,  SZ_HALF, 6'h21, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_5755},
        '{MEM_LOAD,  SZ_BYTE, 6'h11, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00C3},
        '{MEM_NOP,   SZ_WORD, 6'h3C, 32'hDEAD_BEEF, 1'b1, 1'b1, 32'h0000_003C},
        '{MEM_NOP,   SZ_WORD, 6'h05, 32'hDEAD_BEEF, 1'b1, 1'b0, 32'h0000_0005},
        '{MEM_NOP,   SZ_WORD, 6'h06, 32'hDEAD_BEEF, 1'b0, 1'b1, 32'h0000_0006},
        '{MEM_STORE, SZ_WORD, 6'h3E, 32'h1122_3344, 1'b1, 1'b1, 32'h0000_003E},
        '{MEM_LOAD,  SZ_WORD, 6'h00, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_1122},
        '{MEM_LOAD,  SZ_WORD, 6'h0F, 32'h0000_0000, 1'b1, 1'b1, 32'hB2C3_D488}
    };

    mem_stage_top #(
        .MEM_BYTES(MEM_BYTES),
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RES_CREDITS(RES_CREDITS)
    ) mem_stage_top_inst (
        .clk(clk), .rst(rst),
        .i_req_valid(i_req_valid), .i_req_op(i_req_op), .i_req_size(i_req_size),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
        .i_req_zero(i_req_zero), .i_req_branch(i_req_branch),
        .i_res_credit(i_res_credit), .i_dbg_addr(i_dbg_addr),
        .o_req_credit(o_req_credit), .o_res_valid(o_res_valid), .o_res_data(o_res_data),
        .o_res_pc_src(o_res_pc_src), .o_res_is_load(o_res_is_load), .o_dbg_data(o_dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            SZ_TRI:  return 3;
            default: return 4;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] base);
        logic [DATA_W-1:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = ref_mem[base + ADDR_W'(k)];   // Lowest address in the low byte
        end
        return w;
    endfunction

    // Applies one request to the reference model and records its result
    task automatic predict(input stim_t s);
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] a;
        data = (s.op == MEM_LOAD) ? '0 : DATA_W'(s.addr);
        for (int k = 0; k < size_bytes(s.size); k++) begin
            a = s.addr + ADDR_W'(k);
            if (s.op == MEM_STORE) begin
                ref_mem[a] = s.wdata[8*k +: 8];
            end else if (s.op == MEM_LOAD) begin
                data[8*k +: 8] = ref_mem[a];
            end
        end
        check_value($sformatf("table entry %0d", sent), s.exp_data, data);
        exp_data[IDX_W'(sent)] = data;
        exp_pc[IDX_W'(sent)]   = s.zero & s.branch;
        exp_load[IDX_W'(sent)] = (s.op == MEM_LOAD);
        sent++;
    endtask

    task automatic send_req(input int idx);
        stim_t s;
        int    waited;
        s      = stim[IDX_W'(idx)];
        waited = 0;
        @(posedge clk);
        while (QUEUE_DEPTH + credits_back - sent <= 0) begin
            i_req_valid <= 1'b0;              // Out of execute credits
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("an execute-side credit");
            end
            @(posedge clk);
        end
        i_req_valid  <= 1'b1;
        i_req_op     <= s.op;
        i_req_size   <= s.size;
        i_req_addr   <= s.addr;
        i_req_wdata  <= s.wdata;
        i_req_zero   <= s.zero;
        i_req_branch <= s.branch;
        predict(s);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!(results_seen == sent && owed == 0)) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("all results and writeback credits");
            end
        end
    endtask

    task automatic check_debug(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        i_dbg_addr <= a;
        repeat (2) @(posedge clk);            // Sampled at the next edge and read one later
        check_value($sformatf("debug word at 0x%0h", a), model_word(a), o_dbg_data);
    endtask

    task automatic check_result(input int n);
        if (n >= sent) begin
            $display("A result appeared with no request outstanding");
            abort_run();
        end else begin
            check_value($sformatf("result %0d data", n), exp_data[IDX_W'(n)], o_res_data);
            check_value($sformatf("result %0d pc_src", n), 32'(exp_pc[IDX_W'(n)]),
                        32'(o_res_pc_src));
            check_value($sformatf("result %0d is_load", n), 32'(exp_load[IDX_W'(n)]),
                        32'(o_res_is_load));
        end
    endtask

    always @(posedge clk) begin
        if (!rst && o_req_credit) begin
            credits_back <= credits_back + 1;
        end
    end

    // Writeback model returns one credit per result after a random gap
    always @(posedge clk) begin
        int owed_n;
        owed_n = owed;
        i_res_credit <= 1'b0;
        if (!rst && o_res_valid) begin
            check_result(results_seen);
            results_seen <= results_seen + 1;
            owed_n = owed_n + 1;
        end
        if (!rst && !hold_credits && owed_n > 0) begin
            if (gap == 0) begin
                i_res_credit <= 1'b1;
                owed_n = owed_n - 1;
                gap <= $random(seed) & 3;
            end else begin
                gap <= gap - 1;
            end
        end
        owed <= owed_n;
    end

    initial begin
        int seen_mark;
        int pulse_mark;
        rst          = 1'b1;
        i_req_valid  = 1'b0;
        i_req_op     = MEM_NOP;
        i_req_size   = SZ_WORD;
        i_req_addr   = '0;
        i_req_wdata  = '0;
        i_req_zero   = 1'b0;
        i_req_branch = 1'b0;
        i_dbg_addr   = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[ADDR_W'(i)] = 8'h00;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            check_debug(ADDR_W'(a));          // Every byte is zero after reset
        end

        for (int i = 0; i < HOLD_FIRST; i++) begin
            send_req(i);
        end
        @(posedge clk);
        i_req_valid <= 1'b0;
        wait_drain();

        // Writeback stops returning credits so only RES_CREDITS pops may happen
        @(posedge clk);
        hold_credits <= 1'b1;
        seen_mark  = results_seen;
        pulse_mark = credits_back;
        for (int i = HOLD_FIRST; i < NUM_REQ; i++) begin
            send_req(i);
        end
        @(posedge clk);
        i_req_valid <= 1'b0;
        repeat (12) @(posedge clk);
        check_value("results while credits withheld", 32'(RES_CREDITS),
                    32'(results_seen - seen_mark));
        check_value("execute credits while credits withheld", 32'(RES_CREDITS),
                    32'(credits_back - pulse_mark));
        hold_credits <= 1'b0;
        wait_drain();

        for (int a = 0; a < MEM_BYTES; a += 4) begin
            check_debug(ADDR_W'(a));
        end
        check_debug(6'h3E);                   // Word that wraps past the top address

        if (results_seen == NUM_REQ && sent == NUM_REQ) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("Saw %0d results for %0d requests", results_seen, sent);
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
mem_stage_pkg.sv
mem_req_queue.sv
data_memory.sv
mem_access_ctrl.sv
mem_stage_top.sv
mem_stage_assert.sv
tb_mem_stage.sv

// ==== Makefile ====
# Verilator build and run of the memory stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vtb_mem_stage: vlog.f *.sv
	verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f vlog.f

test: obj_dir/Vtb_mem_stage
	./obj_dir/Vtb_mem_stage | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
